// File: sim.f
+incdir+verilog
verilog/sparse_buffer_pkg.sv
verilog/fifo_if.sv
verilog/sample_discriminator.sv
verilog/capture_fifo.sv
verilog/buffer_readout.sv
verilog/sparse_sample_buffer.sv
tb/sparse_sample_buffer_tb.sv

// File: Makefile
# Verilator lint and simulation of the sparse sample capture testbench

VERILATOR  ?= verilator
TOP        := sparse_sample_buffer_tb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
FLAGS      := --timing --assert -f $(FILELIST) --top-module $(TOP)
LINT_FLAGS := --lint-only -Wall
SIM_FLAGS  := --binary -Wno-fatal --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(FLAGS)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb/sparse_sample_buffer_tb.sv
// testbench for the sparse sample capture top level
// runs captures against a model of the hysteresis rule and checks every
// readout word, its flags, capture_done and the hold rule under back-pressure

`timescale 1ns/1ns
`default_nettype none

`include "sparse_buffer_macros.svh"

module sparse_sample_buffer_tb;

  import sparse_buffer_pkg::*;

  logic      clk = 1'b0;
  logic      reset;
  logic      sample_valid;
  sample_t   sample_data;
  sample_t   threshold_high;
  sample_t   threshold_low;
  logic      capture_start;
  logic      capture_stop;
  logic      capture_done;
  logic      out_valid;
  logic      out_ready;
  out_word_t out_data;
  logic      out_is_tstamp;
  logic      out_last;

  integer seed = 73;
  string  test_name = "reset";
  logic   ready_random = 1'b0;

  // model state and expected readout, timestamps first
  tstamp_t exp_ts[$];
  sample_t exp_smp[$];
  logic    m_capturing = 1'b0;
  logic    m_done = 1'b0;
  logic    m_armed;
  logic    m_prev_kept;
  tstamp_t m_index;
  sample_t m_hi;
  sample_t m_lo;

  // previous cycle was a stall
  logic      held_stall = 1'b0;
  out_word_t held_data;

  sparse_sample_buffer sparse_sample_buffer_inst (.*);

  always #4 clk = ~clk;

  task automatic report_mismatch(input string what, input out_word_t expected,
                                 input out_word_t actual);
    $display("FAIL %s: %s expected %h actual %h", test_name, what, expected, actual);
    $display("TB FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_failure(input string what);
    $display("%s: %s", test_name, what);
    $display("TB FAILED");
    $fatal(1, "%s", what);
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic void model_sample(input sample_t d);
    logic keep;
    logic run;
    if (m_capturing) begin
      keep = (d > m_hi) || (!(d < m_lo) && m_armed);
      run  = keep && !m_prev_kept;
      if (keep && (exp_smp.size() == `DATA_DEPTH ||
                   (run && exp_ts.size() == `TSTAMP_DEPTH))) begin
        // refused write, capture ends as done
        m_capturing = 1'b0;
        m_done      = 1'b1;
      end else begin
        if (d > m_hi) m_armed = 1'b1;
        else if (d < m_lo) m_armed = 1'b0;
        if (run) exp_ts.push_back(m_index);
        if (keep) exp_smp.push_back(d);
        m_prev_kept = keep;
        m_index     = m_index + tstamp_t'(1);
      end
    end
  endfunction

  // kind 0 above, 1 straddling with gaps, 2 runs of one, 3 below
  task automatic drive_sample(input int kind, input int i, input sample_t hi, input sample_t lo);
    logic [31:0] r;
    sample_t     d;
    logic        v;
    r = $random(seed);
    v = 1'b1;
    case (kind)
      0: d = hi + 16'd1 + sample_t'(r[11:0]);
      1: begin
        v = r[20:19] != 2'b00;
        case (r[18:16])
          3'd0: d = hi + 16'd1 + sample_t'(r[7:0]);
          3'd1: d = lo - 16'd1 - sample_t'(r[7:0]);
          3'd2: d = hi;
          3'd3: d = lo;
          default: d = lo + r[15:0] % (hi - lo + 16'd1);
        endcase
      end
      2: d = i[0] ? lo - 16'd1 : hi + 16'd1;
      default: d = lo - 16'd1 - sample_t'(r[11:0]);
    endcase
    @(posedge clk);
    sample_valid <= v;
    sample_data  <= d;
    if (v) model_sample(d);
  endtask

  task automatic check_done_flag();
    assert (capture_done == m_done)
      else report_mismatch("capture_done", out_word_t'(m_done), out_word_t'(capture_done));
  endtask

  // a start counts only while nothing is captured or left to read out
  task automatic start_capture(input sample_t hi, input sample_t lo);
    logic accept;
    accept = !m_capturing && exp_ts.size() == 0 && exp_smp.size() == 0;
    @(posedge clk);
    sample_valid   <= 1'b0;
    threshold_high <= hi;
    threshold_low  <= lo;
    capture_start  <= 1'b1;
    @(posedge clk);
    capture_start <= 1'b0;
    if (accept) begin
      m_capturing = 1'b1;
      m_done      = 1'b0;
      m_armed     = 1'b0;
      m_prev_kept = 1'b0;
      m_index     = '0;
      m_hi        = hi;
      m_lo        = lo;
    end
    @(posedge clk);
    check_done_flag();
  endtask

  task automatic end_capture();
    repeat (2) begin
      @(posedge clk);
      sample_valid <= 1'b0;
    end
    @(posedge clk);
    capture_stop <= 1'b1;
    @(posedge clk);
    capture_stop <= 1'b0;
    m_capturing = 1'b0;
    @(posedge clk);
    check_done_flag();
  endtask

  task automatic wait_first_word();
    int cycles;
    cycles = 0;
    while (!out_valid) begin
      @(posedge clk);
      cycles++;
      if (cycles > 500) report_failure("timed out waiting for the first output word");
    end
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (exp_ts.size() + exp_smp.size() != 0) begin
      @(posedge clk);
      cycles++;
      if (cycles > 2000) report_failure("timed out waiting for readout to finish");
    end
    repeat (4) @(posedge clk);
    check_done_flag();
  endtask

  task automatic run_capture(input string name, input sample_t hi, input sample_t lo,
                             input int kind, input int count, input logic poke);
    test_name = name;
    start_capture(hi, lo);
    for (int i = 0; i < count; i++) begin
      drive_sample(kind, i, hi, lo);
      if (poke && i == count / 2) start_capture(16'hffff, 16'hfffe);
    end
    end_capture();
    if (poke && exp_smp.size() != 0) begin
      wait_first_word();
      start_capture(16'hffff, 16'hfffe);
    end
    wait_drained();
  endtask

  //////////////////////////////
  // output checks
  //////////////////////////////

  always @(posedge clk) begin
    logic [31:0] r;
    r = $random(seed);
    out_ready <= ready_random ? (r[0] | r[1]) : 1'b1;
  end

  always @(posedge clk) begin
    int        left;
    out_word_t want;
    logic      want_ts;
    if (!reset) begin
      left = exp_ts.size() + exp_smp.size();
      if (held_stall) begin
        assert (out_valid) else report_failure("out_valid dropped while out_ready was low");
        assert (out_data == held_data) else report_mismatch("held out_data", held_data, out_data);
      end
      assert (out_valid || !out_last) else report_failure("out_last high without out_valid");
      if (out_valid) begin
        assert (left != 0) else report_failure("output word sent with nothing left to send");
        if (left != 0) begin
          want_ts = exp_ts.size() != 0;
          if (want_ts) want = exp_ts[0];
          else want = out_word_t'(exp_smp[0]);
          assert (out_data == want) else report_mismatch("out_data", want, out_data);
          assert (out_is_tstamp == want_ts)
            else report_mismatch("out_is_tstamp", out_word_t'(want_ts), out_word_t'(out_is_tstamp));
          assert (out_last == (left == 1))
            else report_mismatch("out_last", out_word_t'(left == 1), out_word_t'(out_last));
          if (out_ready && want_ts) void'(exp_ts.pop_front());
          if (out_ready && !want_ts) void'(exp_smp.pop_front());
        end
      end
      held_stall = out_valid && !out_ready;
      held_data  = out_data;
    end
  end

  initial begin
    repeat (50000) @(posedge clk);
    $display("TB FAILED");
    $fatal(1, "simulation did not finish within its cycle limit");
  end

  initial begin
    reset          = 1'b1;
    sample_valid   = 1'b0;
    sample_data    = '0;
    threshold_high = '0;
    threshold_low  = '0;
    capture_start  = 1'b0;
    capture_stop   = 1'b0;
    out_ready      = 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    assert (!capture_done && !out_valid && !out_last)
      else report_failure("outputs not low after reset");
    run_capture("all_above_stop", 16'h0100, 16'h0080, 0, 12, 1'b0);
    ready_random <= 1'b1;
    run_capture("random_strong", 16'h9000, 16'h3000, 1, 50, 1'b0);
    run_capture("random_weak", 16'h8000, 16'h7f00, 1, 50, 1'b0);
    ready_random <= 1'b0;
    run_capture("fill_samples", 16'h1000, 16'h0800, 0, `DATA_DEPTH + 8, 1'b0);
    run_capture("fill_tstamps", 16'h1000, 16'h0800, 2, 2 * `TSTAMP_DEPTH + 6, 1'b0);
    // nothing kept, so any word in this window is an error
    run_capture("all_below", 16'h8000, 16'h4000, 3, 20, 1'b0);
    repeat (40) @(posedge clk);
    run_capture("restart_after_empty", 16'h8000, 16'h4000, 0, 5, 1'b0);
    ready_random <= 1'b1;
    run_capture("start_ignored", 16'h9000, 16'h3000, 1, 40, 1'b1);
    run_capture("backpressure", 16'h0100, 16'h0080, 0, 40, 1'b0);
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/sparse_sample_buffer.sv
// top level of the single-channel sparse sample capture
// discriminator fills a timestamp buffer and a sample buffer, readout drains
// them onto the output stream after capture ends

`timescale 1ns/1ns
`default_nettype none

`include "sparse_buffer_macros.svh"

module sparse_sample_buffer (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         sample_valid,
  input  sparse_buffer_pkg::sample_t   sample_data,
  input  sparse_buffer_pkg::sample_t   threshold_high,
  input  sparse_buffer_pkg::sample_t   threshold_low,
  input  logic                         capture_start,
  input  logic                         capture_stop,
  output logic                         capture_done,
  output logic                         out_valid,
  input  logic                         out_ready,
  output sparse_buffer_pkg::out_word_t out_data,
  output logic                         out_is_tstamp,
  output logic                         out_last
);

  import sparse_buffer_pkg::*;

  logic capturing;
  logic readout_busy;

  fifo_if #(.payload_t(tstamp_t)) ts_bus ();
  fifo_if #(.payload_t(sample_t)) smp_bus ();

  ////////////////////////////
  // producer
  ////////////////////////////

  sample_discriminator disc_inst (
    .clk,
    .reset,
    .sample_valid,
    .sample_data,
    .threshold_high,
    .threshold_low,
    .capture_start,
    .capture_stop,
    .readout_busy,
    .capture_done,
    .capturing,
    .ts_bus  (ts_bus.writer),
    .smp_bus (smp_bus.writer)
  );

  // run start timestamps
  capture_fifo #(
    .payload_t (tstamp_t),
    .DEPTH     (`TSTAMP_DEPTH)
  ) ts_fifo (
    .clk,
    .reset,
    .bus (ts_bus.buffer)
  );

  // kept samples
  capture_fifo #(
    .payload_t (sample_t),
    .DEPTH     (`DATA_DEPTH)
  ) smp_fifo (
    .clk,
    .reset,
    .bus (smp_bus.buffer)
  );

  ////////////////////////////
  // consumer
  ////////////////////////////

  buffer_readout readout_inst (
    .clk,
    .reset,
    .capturing,
    .ts_bus  (ts_bus.reader),
    .smp_bus (smp_bus.reader),
    .out_valid,
    .out_ready,
    .out_data,
    .out_is_tstamp,
    .out_last,
    .readout_busy
  );

endmodule

`default_nettype wire

// File: verilog/buffer_readout.sv
// readout of a finished capture onto a valid/ready stream
// sends every timestamp first, then every sample, flagging the final word
// waits while a capture is running

`timescale 1ns/1ns
`default_nettype none

module buffer_readout (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          capturing,
  fifo_if.reader                        ts_bus,
  fifo_if.reader                        smp_bus,
  output logic                          out_valid,
  input  logic                          out_ready,
  output sparse_buffer_pkg::out_word_t  out_data,
  output logic                          out_is_tstamp,
  output logic                          out_last,
  output logic                          readout_busy
);

  import sparse_buffer_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_TS,
    ST_SMP
  } state_t;

  state_t state;

  // output register can take a new word
  logic load_ok;

  assign load_ok = !out_valid || out_ready;

  // pop the buffer of the current phase whenever the output register is free
  assign ts_bus.rd_ready  = (state == ST_TS) && load_ok;
  assign smp_bus.rd_ready = (state == ST_SMP) && load_ok;

  // held word is last once both buffers are drained
  assign out_last = out_valid && !ts_bus.rd_valid && !smp_bus.rd_valid;

  assign readout_busy = ts_bus.rd_valid || smp_bus.rd_valid || out_valid;

  ////////////////////////////
  // phase FSM and valid
  ////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      out_valid <= 1'b0;
    end else begin
      if (out_valid && out_ready) begin
        out_valid <= 1'b0;
      end
      case (state)
        ST_IDLE: begin
          if (!capturing && (ts_bus.rd_valid || smp_bus.rd_valid)) begin
            state <= ST_TS;
          end
        end
        ST_TS: begin
          if (load_ok) begin
            if (ts_bus.rd_valid) begin
              out_valid <= 1'b1;
            end else begin
              state <= ST_SMP;
            end
          end
        end
        ST_SMP: begin
          if (load_ok) begin
            if (smp_bus.rd_valid) begin
              out_valid <= 1'b1;
            end else begin
              state <= ST_IDLE;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////
  // output word
  ////////////////////////////

  always_ff @(posedge clk) begin
    if (load_ok && (state == ST_TS) && ts_bus.rd_valid) begin
      out_data      <= ts_bus.rd_data;
      out_is_tstamp <= 1'b1;
    end else if (load_ok && (state == ST_SMP) && smp_bus.rd_valid) begin
      // samples are zero-extended to the word width
      out_data      <= out_word_t'(smp_bus.rd_data);
      out_is_tstamp <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/capture_fifo.sv
// synchronous register-array FIFO for one capture buffer
// the head entry is shown on rd_data with no latency
// payload_t selects the entry type, DEPTH the number of entries

`timescale 1ns/1ns
`default_nettype none

module capture_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 16
) (
  input  logic   clk,
  input  logic   reset,
  fifo_if.buffer bus
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  payload_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;

  logic push;
  logic pop;

  ////////////////////////////
  // status and head entry
  ////////////////////////////

  assign bus.wr_ready = count != CW'(DEPTH);
  assign bus.rd_valid = count != '0;
  assign bus.rd_data  = mem[rd_ptr];

  assign push = bus.wr_valid && bus.wr_ready;
  assign pop  = bus.rd_valid && bus.rd_ready;

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= bus.wr_data;
    end
  end

  ////////////////////////////
  // pointers and count
  ////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leave the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/sample_discriminator.sv
// hysteresis discriminator and capture control
// keeps samples above the high threshold and those that follow until one
// drops below the low threshold, writing samples and run start indices
// into the two capture buffers

`timescale 1ns/1ns
`default_nettype none

module sample_discriminator (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       sample_valid,
  input  sparse_buffer_pkg::sample_t sample_data,
  input  sparse_buffer_pkg::sample_t threshold_high,
  input  sparse_buffer_pkg::sample_t threshold_low,
  input  logic                       capture_start,
  input  logic                       capture_stop,
  input  logic                       readout_busy,
  output logic                       capture_done,
  output logic                       capturing,
  fifo_if.writer                     ts_bus,
  fifo_if.writer                     smp_bus
);

  import sparse_buffer_pkg::*;

  // thresholds latched on start
  sample_t thresh_high_q;
  sample_t thresh_low_q;

  // compare stage
  logic    s1_valid;
  sample_t s1_data;
  logic    s1_above;
  logic    s1_below;

  // hysteresis and run tracking
  logic    armed;
  logic    prev_kept;
  tstamp_t sample_index;

  logic start_ok;
  logic active;
  logic keep;
  logic run_start;
  logic space_ok;
  logic write_ok;
  logic refused;

  ////////////////////////////
  // decision stage
  ////////////////////////////

  // start only when nothing is captured and nothing left to read out
  assign start_ok = capture_start && !capturing && !readout_busy;

  assign active    = s1_valid && capturing;
  assign keep      = s1_above || (!s1_below && armed);
  assign run_start = keep && !prev_kept;

  // a run start needs room in both buffers
  assign space_ok = smp_bus.wr_ready && (!run_start || ts_bus.wr_ready);
  assign write_ok = active && keep && space_ok;
  assign refused  = active && keep && !space_ok;

  assign smp_bus.wr_valid = write_ok;
  assign smp_bus.wr_data  = s1_data;
  assign ts_bus.wr_valid  = write_ok && run_start;
  assign ts_bus.wr_data   = sample_index;

  ////////////////////////////
  // compare stage registers
  ////////////////////////////

  always_ff @(posedge clk) begin
    if (start_ok) begin
      thresh_high_q <= threshold_high;
      thresh_low_q  <= threshold_low;
    end
    s1_data  <= sample_data;
    s1_above <= sample_data > thresh_high_q;
    s1_below <= sample_data < thresh_low_q;
  end

  ////////////////////////////
  // capture control
  ////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      capturing    <= 1'b0;
      capture_done <= 1'b0;
      s1_valid     <= 1'b0;
      armed        <= 1'b0;
      prev_kept    <= 1'b0;
      sample_index <= '0;
    end else begin
      // samples only enter the pipeline while capturing
      s1_valid <= sample_valid && capturing;
      if (start_ok) begin
        capturing    <= 1'b1;
        capture_done <= 1'b0;
        armed        <= 1'b0;
        prev_kept    <= 1'b0;
        sample_index <= '0;
      end else if (capturing) begin
        if (active) begin
          sample_index <= sample_index + 1'b1;
          prev_kept    <= keep;
          if (s1_above) begin
            armed <= 1'b1;
          end else if (s1_below) begin
            armed <= 1'b0;
          end
        end
        // a full buffer ends the capture and flags it as done
        if (refused) begin
          capturing    <= 1'b0;
          capture_done <= 1'b1;
        end else if (capture_stop) begin
          capturing <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/fifo_if.sv
// write and read handshakes of one capture buffer
// writer pushes entries, buffer holds them, reader pops the head entry

`timescale 1ns/1ns
`default_nettype none

interface fifo_if #(
  parameter type payload_t = logic
);

  // write side
  logic     wr_valid;
  logic     wr_ready;
  payload_t wr_data;

  // read side, rd_data is the head entry
  logic     rd_valid;
  logic     rd_ready;
  payload_t rd_data;

  modport writer (
    output wr_valid, wr_data,
    input  wr_ready
  );

  modport buffer (
    input  wr_valid, wr_data, rd_ready,
    output wr_ready, rd_valid, rd_data
  );

  modport reader (
    input  rd_valid, rd_data,
    output rd_ready
  );

endinterface

`default_nettype wire

// File: verilog/sparse_buffer_pkg.sv
// types shared by the sparse sample capture design
// modules import it in their body and use scoped names in port lists

`default_nettype none

`include "sparse_buffer_macros.svh"

package sparse_buffer_pkg;

  ////////////////////////////
  // data types
  ////////////////////////////

  // one unsigned input sample
  typedef logic [`SAMPLE_WIDTH-1:0] sample_t;

  // sample index since start of capture, wraps at its width
  typedef logic [`TSTAMP_WIDTH-1:0] tstamp_t;

  // readout word, holds a timestamp or a zero-extended sample
  typedef logic [`TSTAMP_WIDTH-1:0] out_word_t;

endpackage

`default_nettype wire

// File: verilog/sparse_buffer_macros.svh
// widths and depths shared by the sparse sample capture design
// include wherever a buffer is sized or a word width is needed

`ifndef SPARSE_BUFFER_MACROS_SVH
`define SPARSE_BUFFER_MACROS_SVH

// bits per input sample
`define SAMPLE_WIDTH 16

// bits per timestamp, also the width of one readout word
`define TSTAMP_WIDTH 20

// sample buffer entries
`define DATA_DEPTH 64

// timestamp buffer entries, one per run of kept samples
`define TSTAMP_DEPTH 16

`endif
